// File: logic/sg_bus_config.svh
// Build-time sizes for the shared memory port.
// SG_MEM_DEPTH must not exceed 2**SG_ADR_W, and SG_SEL_W must equal SG_DAT_W/8.
`ifndef SG_BUS_CONFIG_SVH
`define SG_BUS_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////////////////////////

`define SG_NUM_MASTERS 5       // Masters sharing the port, also the gnt width.
`define SG_ADR_W       10      // Word address width seen by every master.
`define SG_DAT_W       32      // Data bus width in bits.
`define SG_SEL_W       4       // One byte select per byte lane.

//////////////////////////////////////////////////////////////////////
// Buffer memory
//////////////////////////////////////////////////////////////////////

// Words at or above this address are not implemented and answer with err.
`define SG_MEM_DEPTH   768

// Cycles spent in MEM_WAIT before the one-cycle reply.
`define SG_MEM_WAIT    1

`endif

// File: logic/sg_bus_pkg.sv
// Types shared by the memory port RTL and its testbench.
// master_idx_t is fixed at 3 bits and so covers at most 8 masters.
`default_nettype none

package sg_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // Memory slave FSM
   //////////////////////////////////////////////////////////////////////

   // Idle waits for cyc and stb, wait counts the wait states, and
   // reply holds ack or err for exactly one cycle.
   typedef enum logic [1:0] {
      MEM_IDLE  = 2'd0,   // No transfer in progress.
      MEM_WAIT  = 2'd1,   // Request taken, wait states running.
      MEM_REPLY = 2'd2    // Ack or err is driven in this state.
   } mem_state_e;

   //////////////////////////////////////////////////////////////////////
   // Master numbering
   //////////////////////////////////////////////////////////////////////

   // Binary index of one master, used where the one-hot grant has to
   // address a field of a per-master vector.
   typedef logic [2:0] master_idx_t;

endpackage

`default_nettype wire

// File: logic/sg_arbiter.sv
// Round-robin owner of the shared bus; the grant only moves when the holder drops cyc.
// A master that never releases cyc keeps the bus for good, there is no timeout.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_arbiter (
   input  logic                       wb_clk_i,
   input  logic                       wb_rst_i,
   input  logic [`SG_NUM_MASTERS-1:0] cyc,
   output logic [`SG_NUM_MASTERS-1:0] gnt
);

   import sg_bus_pkg::*;

   localparam int NUM_M = `SG_NUM_MASTERS;   // Short name for the loops below.

   master_idx_t               holder;       // Index of the master holding gnt.
   logic [NUM_M-1:0]          gnt_n;        // Grant for the next cycle.

   //////////////////////////////////////////////////////////////////////
   // Current holder
   //////////////////////////////////////////////////////////////////////

   // The grant is one-hot, so the last set bit is the only set bit.
   always_comb begin
      holder = '0;                                   // Master 0 if nothing matches.
      for (int i = 0; i < NUM_M; i++) begin
         if (gnt[i]) begin
            holder = master_idx_t'(i);               // Record the owner index.
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Next holder search
   //////////////////////////////////////////////////////////////////////

   // Walk the masters in cyclic order starting just after the holder.
   // The first one with cyc high wins; if nobody else asks, keep the grant
   // where it is so the bus stays parked on the last user.
   always_comb begin
      int   cand;                                    // Candidate master index.
      logic found;                                   // A requester was picked.
      gnt_n = gnt;                                   // Default is to hold the grant.
      found = 1'b0;
      cand  = 0;
      if (!cyc[holder]) begin                        // Holder released the bus.
         for (int off = 1; off < NUM_M; off++) begin
            cand = (int'(holder) + off) % NUM_M;     // Wrap around the ring.
            if (!found && cyc[cand]) begin
               gnt_n       = '0;                     // Clear the old owner.
               gnt_n[cand] = 1'b1;                   // Hand over to the candidate.
               found       = 1'b1;                   // Stop at the first one.
            end
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Grant register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         gnt <= NUM_M'(1);                           // Master 0 owns the bus after reset.
      end else begin
         gnt <= gnt_n;                               // Moves only on a release.
      end
   end

endmodule

`default_nettype wire

// File: logic/sg_bus_mux.sv
// Combinational request and reply routing between the masters and the single slave.
// Assumes gnt is one-hot; with several bits set the highest one is routed.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_bus_mux (
   input  logic [`SG_NUM_MASTERS-1:0]           gnt,
   input  logic [`SG_NUM_MASTERS-1:0]           cyc,
   input  logic [`SG_NUM_MASTERS-1:0]           stb,
   input  logic [`SG_NUM_MASTERS-1:0]           we,
   input  logic [`SG_NUM_MASTERS*`SG_ADR_W-1:0] adr,
   input  logic [`SG_NUM_MASTERS*`SG_SEL_W-1:0] sel,
   input  logic [`SG_NUM_MASTERS*`SG_DAT_W-1:0] dat_w,
   output logic [`SG_NUM_MASTERS-1:0]           ack,
   output logic [`SG_NUM_MASTERS-1:0]           err,
   output logic                                 s_cyc,
   output logic                                 s_stb,
   output logic                                 s_we,
   output logic [`SG_ADR_W-1:0]                 s_adr,
   output logic [`SG_SEL_W-1:0]                 s_sel,
   output logic [`SG_DAT_W-1:0]                 s_dat_w,
   input  logic                                 s_ack,
   input  logic                                 s_err
);

   import sg_bus_pkg::*;

   localparam int NUM_M = `SG_NUM_MASTERS;

   master_idx_t gnt_idx;                        // Binary form of the one-hot grant.

   //////////////////////////////////////////////////////////////////////
   // Grant encoder
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      gnt_idx = '0;
      for (int i = 0; i < NUM_M; i++) begin
         if (gnt[i]) begin
            gnt_idx = master_idx_t'(i);         // Only one bit is expected to be set.
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Request path toward the slave
   //////////////////////////////////////////////////////////////////////

   // Only the granted master's fields pass, so an ungranted stb is never
   // seen by the memory and that master simply waits.
   assign s_cyc   = cyc[gnt_idx];                                 // Owner's cycle.
   assign s_stb   = stb[gnt_idx];                                 // Owner's strobe.
   assign s_we    = we[gnt_idx];                                  // Owner's direction.
   assign s_adr   = adr[gnt_idx*`SG_ADR_W +: `SG_ADR_W];          // Owner's word address.
   assign s_sel   = sel[gnt_idx*`SG_SEL_W +: `SG_SEL_W];          // Owner's byte lanes.
   assign s_dat_w = dat_w[gnt_idx*`SG_DAT_W +: `SG_DAT_W];        // Owner's write data.

   //////////////////////////////////////////////////////////////////////
   // Reply path back to the owner
   //////////////////////////////////////////////////////////////////////

   // The one-hot grant doubles as the reply mask, every other bit stays low.
   assign ack = gnt & {NUM_M{s_ack}};           // Ack lands on the owner only.
   assign err = gnt & {NUM_M{s_err}};           // Same for the error reply.

endmodule

`default_nettype wire

// File: logic/sg_mem_slave.sv
// Wishbone classic SRAM slave; the master must hold adr, we, sel and dat_w until ack or err.
// Words at or above SG_MEM_DEPTH answer with err. The array powers up undefined.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_mem_slave (
   input  logic                 wb_clk_i,
   input  logic                 wb_rst_i,
   input  logic                 s_cyc,
   input  logic                 s_stb,
   input  logic                 s_we,
   input  logic [`SG_ADR_W-1:0] s_adr,
   input  logic [`SG_SEL_W-1:0] s_sel,
   input  logic [`SG_DAT_W-1:0] s_dat_w,
   output logic                 s_ack,
   output logic                 s_err,
   output logic [`SG_DAT_W-1:0] s_dat_r
);

   import sg_bus_pkg::*;

   // Counter is at least one bit wide even when no wait states are configured.
   localparam int                WAIT_W    = (`SG_MEM_WAIT > 1) ? $clog2(`SG_MEM_WAIT) : 1;
   localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'((`SG_MEM_WAIT > 0) ? `SG_MEM_WAIT - 1 : 0);

   mem_state_e        state;                    // Transfer FSM.
   logic [WAIT_W-1:0] wait_cnt;                 // Wait states spent so far.
   logic              err_q;                    // Current reply is an error.
   logic              req;                      // Valid request on the bus.
   logic              in_range;                 // Address hits an implemented word.
   logic              enter_reply;              // The next edge starts MEM_REPLY.

   logic [`SG_DAT_W-1:0] mem [`SG_MEM_DEPTH];   // Buffer storage, one word per address.

   //////////////////////////////////////////////////////////////////////
   // Request decode
   //////////////////////////////////////////////////////////////////////

   assign req      = s_cyc && s_stb;                   // Classic cycle is cyc and stb.
   assign in_range = (s_adr < `SG_MEM_DEPTH);          // Upper part of the map is a hole.

   // With no wait states the reply follows the request edge directly.
   assign enter_reply = ((state == MEM_IDLE) && req && (`SG_MEM_WAIT == 0)) ||
                        ((state == MEM_WAIT) && (wait_cnt == WAIT_LAST));

   //////////////////////////////////////////////////////////////////////
   // Transfer FSM
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state    <= MEM_IDLE;
         wait_cnt <= '0;
         err_q    <= 1'b0;
      end else begin
         case (state)
            MEM_IDLE: begin
               wait_cnt <= '0;                          // Fresh count per transfer.
               if (req) begin
                  state <= (`SG_MEM_WAIT == 0) ? MEM_REPLY : MEM_WAIT;
               end
            end
            MEM_WAIT: begin
               if (wait_cnt == WAIT_LAST) begin
                  state <= MEM_REPLY;                   // Last wait state done.
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            MEM_REPLY: begin
               state <= MEM_IDLE;                       // Reply lasts one cycle only.
            end
            default: begin
               state <= MEM_IDLE;                       // Unused code, recover.
            end
         endcase
         if (enter_reply) begin
            err_q <= !in_range;                         // Kind of reply to give.
         end
      end
   end

   // Ack and err come straight from the state, so each is one cycle wide.
   assign s_ack = (state == MEM_REPLY) && !err_q;
   assign s_err = (state == MEM_REPLY) && err_q;

   //////////////////////////////////////////////////////////////////////
   // Storage access
   //////////////////////////////////////////////////////////////////////

   // The access happens on the edge into MEM_REPLY using the held bus
   // fields, so read data is valid for the whole ack cycle. An error
   // reply leaves both the array and s_dat_r untouched.
   always_ff @(posedge wb_clk_i) begin
      if (enter_reply && in_range) begin
         if (s_we) begin
            for (int b = 0; b < `SG_SEL_W; b++) begin
               if (s_sel[b]) begin
                  mem[s_adr][b*8 +: 8] <= s_dat_w[b*8 +: 8];   // Selected lane only.
               end
            end
         end else begin
            s_dat_r <= mem[s_adr];                              // Whole word, sel ignored.
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/sg_bus_top.sv
// Shared scatter-gather memory port: arbiter, request mux and SRAM slave.
// dat_r is common to all masters and only meaningful with that master's ack.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_bus_top (
   input  logic                                 wb_clk_i,
   input  logic                                 wb_rst_i,
   input  logic [`SG_NUM_MASTERS-1:0]           cyc,
   input  logic [`SG_NUM_MASTERS-1:0]           stb,
   input  logic [`SG_NUM_MASTERS-1:0]           we,
   input  logic [`SG_NUM_MASTERS*`SG_ADR_W-1:0] adr,
   input  logic [`SG_NUM_MASTERS*`SG_SEL_W-1:0] sel,
   input  logic [`SG_NUM_MASTERS*`SG_DAT_W-1:0] dat_w,
   output logic [`SG_NUM_MASTERS-1:0]           ack,
   output logic [`SG_NUM_MASTERS-1:0]           err,
   output logic [`SG_DAT_W-1:0]                 dat_r
);

   logic [`SG_NUM_MASTERS-1:0] gnt;             // One-hot bus owner.
   logic                       s_cyc;           // Owner's request toward the memory.
   logic                       s_stb;
   logic                       s_we;
   logic [`SG_ADR_W-1:0]       s_adr;
   logic [`SG_SEL_W-1:0]       s_sel;
   logic [`SG_DAT_W-1:0]       s_dat_w;
   logic                       s_ack;           // Memory reply before routing.
   logic                       s_err;

   sg_arbiter sg_arbiter_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc      (cyc),
      .gnt      (gnt)
   );

   sg_bus_mux sg_bus_mux_inst (
      .gnt     (gnt),
      .cyc     (cyc),
      .stb     (stb),
      .we      (we),
      .adr     (adr),
      .sel     (sel),
      .dat_w   (dat_w),
      .ack     (ack),
      .err     (err),
      .s_cyc   (s_cyc),
      .s_stb   (s_stb),
      .s_we    (s_we),
      .s_adr   (s_adr),
      .s_sel   (s_sel),
      .s_dat_w (s_dat_w),
      .s_ack   (s_ack),
      .s_err   (s_err)
   );

   sg_mem_slave sg_mem_slave_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .s_cyc    (s_cyc),
      .s_stb    (s_stb),
      .s_we     (s_we),
      .s_adr    (s_adr),
      .s_sel    (s_sel),
      .s_dat_w  (s_dat_w),
      .s_ack    (s_ack),
      .s_err    (s_err),
      .s_dat_r  (dat_r)                         // Read data goes out unrouted.
   );

endmodule

`default_nettype wire

// File: verification/sg_bus_assertions.sv
// Reply-side protocol checks for the shared memory port, bound into sg_bus_top.
// All checks are off while reset is high.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_bus_assertions (
   input logic                       wb_clk_i,
   input logic                       wb_rst_i,
   input logic [`SG_NUM_MASTERS-1:0] cyc,
   input logic [`SG_NUM_MASTERS-1:0] stb,
   input logic [`SG_NUM_MASTERS-1:0] ack,
   input logic [`SG_NUM_MASTERS-1:0] err
);

   int unsigned fail_count = 0;                 // Number of failed assertions so far.

   //////////////////////////////////////////////////////////////////////
   // Reply shape
   //////////////////////////////////////////////////////////////////////

   ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (ack & err) == '0)                        // A reply is ack or err, not both.
      else begin
         $error("ack and err are high together for one master");
         fail_count++;
      end

   reply_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $onehot0(ack | err))                      // One slave, so one reply at a time.
      else begin
         $error("more than one master sees a reply in the same cycle");
         fail_count++;
      end

   reply_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (ack | err) != '0 |=> (ack | err) == '0)  // The slave leaves MEM_REPLY after one cycle.
      else begin
         $error("a reply stayed high for more than one cycle");
         fail_count++;
      end

   //////////////////////////////////////////////////////////////////////
   // Per-master isolation
   //////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `SG_NUM_MASTERS; i++) begin : g_master
      // A reply may only start for a master that has a live request.
      reply_requested: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
         $rose(ack[i] || err[i]) |-> (cyc[i] && stb[i]))
         else begin
            $error("master %0d got a reply without cyc and stb high", i);
            fail_count++;
         end
   end

endmodule

`default_nettype wire

// File: verification/sg_bus_tb.sv
// Directed and seeded-random testbench for the shared memory port.
// Checks read data, reply order and first-access latency; protocol rules sit in the bound module.
`timescale 1ns/1ps
`default_nettype none

`include "sg_bus_config.svh"

module sg_bus_tb;

   import sg_bus_pkg::*;

   localparam int NM         = `SG_NUM_MASTERS;
   localparam int AW         = `SG_ADR_W;
   localparam int DW         = `SG_DAT_W;
   localparam int SW         = `SG_SEL_W;
   localparam int CLK_PERIOD = 20;
   localparam int N_XFERS    = 51;              // Transfers issued by all tests together.

   logic             wb_clk_i = 1'b0;
   logic             wb_rst_i = 1'b1;
   logic [NM-1:0]    cyc      = '0;
   logic [NM-1:0]    stb      = '0;
   logic [NM-1:0]    we       = '0;
   logic [NM*AW-1:0] adr      = '0;
   logic [NM*SW-1:0] sel      = '0;
   logic [NM*DW-1:0] dat_w    = '0;
   logic [NM-1:0]    ack;
   logic [NM-1:0]    err;
   logic [DW-1:0]    dat_r;

   integer        seed = 32'h9060_3df5;
   int            errors = 0;                   // Failed testbench checks.
   int            a_fails;                      // Failed bound assertions.
   int            done_cnt;                     // Masters finished in a contention test.
   int            lat;                          // Cycles until the last reply.
   master_idx_t   holder = '0;                  // Expected grant owner, parks on the last user.
   master_idx_t   order_q[$];                   // Masters in the order their replies came.
   logic [DW-1:0] ref_mem [`SG_MEM_DEPTH];      // Reference copy of the buffer memory.
   logic [AW-1:0] addrs [8];                    // Words that the tests keep fully written.

   always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

   sg_bus_top sg_bus_top_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .sel      (sel),
      .dat_w    (dat_w),
      .ack      (ack),
      .err      (err),
      .dat_r    (dat_r)
   );

   bind sg_bus_top sg_bus_assertions sg_bus_assertions_inst (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc      (cyc),
      .stb      (stb),
      .ack      (ack),
      .err      (err)
   );

   //////////////////////////////////////////////////////////////////////
   // Checks and reference model
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [DW-1:0] expected,
                              input logic [DW-1:0] actual);
      assert (actual === expected)
      else begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // Only the byte lanes with their select bit set take the new data.
   function automatic void model_write(input logic [AW-1:0] a, input logic [SW-1:0] s,
                                       input logic [DW-1:0] d);
      for (int b = 0; b < SW; b++) begin
         if (s[b]) begin
            ref_mem[a][b*8 +: 8] = d[b*8 +: 8];
         end
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Master tasks
   //////////////////////////////////////////////////////////////////////

   // Starts and ends on a falling edge; keep holds cyc for a locked burst.
   task automatic xfer(input int m, input logic w, input logic [AW-1:0] a,
                       input logic [SW-1:0] s, input logic [DW-1:0] d, input bit keep,
                       output logic [DW-1:0] rdata, output bit got_err, output int cycles);
      cycles = 0;
      cyc[m] = 1'b1;
      stb[m] = 1'b1;
      we[m]  = w;
      adr[m*AW +: AW]   = a;
      sel[m*SW +: SW]   = s;
      dat_w[m*DW +: DW] = d;
      do begin
         @(negedge wb_clk_i);
         cycles++;
      end while (!ack[m] && !err[m]);           // Waits out the grant and the wait states.
      rdata   = dat_r;                          // Read data is stable through the ack cycle.
      got_err = err[m];
      order_q.push_back(master_idx_t'(m));
      @(negedge wb_clk_i);                      // The reply is taken at the rising edge.
      stb[m] = 1'b0;
      cyc[m] = keep;
   endtask

   // Single transfer by a lone requester, which therefore always gets the grant.
   task automatic access(input string name, input int m, input logic w, input logic [AW-1:0] a,
                         input logic [SW-1:0] s, input logic [DW-1:0] d, input bit exp_err,
                         output int cycles);
      logic [DW-1:0] r;
      bit            x;
      xfer(m, w, a, s, d, 1'b0, r, x, cycles);
      holder = master_idx_t'(m);
      check_value({name, " err"}, exp_err, x);
      if (!exp_err && w) begin
         model_write(a, s, d);
      end
      if (!exp_err && !w) begin
         check_value(name, ref_mem[a], r);
      end
   endtask

   task automatic serve(input string name, input int m, input int n);
      logic [DW-1:0] r;
      bit            x;
      int            c;
      for (int k = 0; k < n; k++) begin
         xfer(m, 1'b0, addrs[(m + k) % 8], '1, '0, k < n - 1, r, x, c);
         check_value({name, " err"}, '0, x);     // Every contended word is in range.
         check_value({name, " read"}, ref_mem[addrs[(m + k) % 8]], r);
      end
   endtask

   // All masters request at once; the holder runs burst_len locked reads first.
   task automatic contend(input string name, input int burst_len);
      master_idx_t h;
      master_idx_t exp_m;
      int          k;
      h = holder;
      done_cnt = 0;
      order_q.delete();
      for (int i = 0; i < NM; i++) begin
         fork
            automatic int m = i;
            begin
               serve(name, m, (m == int'(h)) ? burst_len : 1);
               done_cnt++;
            end
         join_none
      end
      wait (done_cnt == NM);
      check_value({name, " replies"}, burst_len + NM - 1, order_q.size());
      for (int i = 0; i < burst_len + NM - 1; i++) begin
         k     = (i < burst_len) ? 0 : i - burst_len + 1;   // Rotation starts after the holder.
         exp_m = master_idx_t'((int'(h) + k) % NM);
         check_value(name, exp_m, order_q[i]);
      end
      holder = master_idx_t'((int'(h) + NM - 1) % NM);      // Last one served keeps the grant.
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      for (int i = 0; i < 8; i++) begin
         addrs[i] = AW'($unsigned($random(seed)) % (`SG_MEM_DEPTH - 1));
      end
      repeat (16) begin
         @(negedge wb_clk_i);
         check_value("reset", '0, {ack, err});
      end
      wb_rst_i = 1'b0;
      @(negedge wb_clk_i);
      check_value("after reset", '0, {ack, err});
      access("first write", 0, 1'b1, addrs[0], '1, $random(seed), 1'b0, lat);
      check_value("first latency", 1 + `SG_MEM_WAIT, lat);
      for (int i = 1; i < 8; i++) begin
         access("full write", i % NM, 1'b1, addrs[i], '1, $random(seed), 1'b0, lat);
      end
      for (int i = 0; i < 8; i++) begin
         access("sel write", int'($unsigned($random(seed)) % NM), 1'b1, addrs[i],
                SW'($random(seed)), $random(seed), 1'b0, lat);
      end
      for (int i = 0; i < 8; i++) begin
         access("readback", int'($unsigned($random(seed)) % NM), 1'b0, addrs[i], '1, '0,
                1'b0, lat);
      end
      repeat (3) contend("round robin", 1);
      contend("locked burst", 4);
      access("edge write", 2, 1'b1, AW'(`SG_MEM_DEPTH - 1), '1, $random(seed), 1'b0, lat);
      access("oob write", 3, 1'b1, AW'(`SG_MEM_DEPTH), '1, $random(seed), 1'b1, lat);
      access("oob read", 4, 1'b0, AW'(`SG_MEM_DEPTH + $unsigned($random(seed)) % 256), '1, '0,
             1'b1, lat);
      access("edge read", 1, 1'b0, AW'(`SG_MEM_DEPTH - 1), '1, '0, 1'b0, lat);
      repeat (4) @(negedge wb_clk_i);
      a_fails = sg_bus_top_inst.sg_bus_assertions_inst.fail_count;
      $display("Check errors: %0d, assertion failures: %0d", errors, a_fails);
      if (errors == 0 && a_fails == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Each transfer gets a generous budget, including time spent waiting for the grant.
   initial begin
      #((16 + N_XFERS * 200) * CLK_PERIOD);
      $display("Timeout: transfers did not finish within %0d cycles", 16 + N_XFERS * 200);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/sg_bus_pkg.sv
logic/sg_arbiter.sv
logic/sg_bus_mux.sv
logic/sg_mem_slave.sv
logic/sg_bus_top.sv
verification/sg_bus_assertions.sv
verification/sg_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the shared memory port testbench with Verilator, runs it and scans the log.
# A non-zero exit status means the build, the run or a check failed.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module sg_bus_tb \
   && ./obj_dir/Vsg_bus_tb +verilator+error+limit+1000 > "$LOG" 2>&1 \
   || { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "Finished with errors" "$LOG" \
   && { echo "Simulation FAILED"; exit 1; }

grep -q "Finished with no errors" "$LOG" \
   || { echo "Simulation ended without a closing report"; exit 1; }

echo "Simulation PASSED"
